/* tests/debug_stim.txt */
// kind_arg_value in hex; kinds 1 host byte, 2 halt pulse with pc byte, 3 write at arg,
// 4 report byte, 5 levels arg = {tx_start, ctrl_clk_mips, debug}, 6 no write pending
5_000_00000000
1_000_00000033
1_000_00000007
6_000_00000000
1_000_00000001 // start
5_001_00000000
1_000_00000078
1_000_00000056
1_000_00000034
1_000_00000012
3_000_12345678
1_000_000000ef
1_000_000000be
1_000_000000ad
1_000_000000de
3_001_deadbeef
1_000_00000000
1_000_00000000
1_000_00000000
1_000_000000fc
3_002_fc000000 // end word
5_000_00000000
1_000_00000005 // reprogram
1_000_000000aa
1_000_00000055
6_000_00000000
5_000_00000000
1_000_00000001
1_000_00000011
1_000_00000022
1_000_00000033
1_000_00000044
3_000_44332211 // address restarts
1_000_00000000
1_000_00000000
1_000_00000000
1_000_000000ff
3_001_ff000000
5_000_00000000
1_000_00000002 // continuous
5_002_00000000
2_000_0000003c
4_000_0000003c
5_000_00000000
1_000_00000001
1_000_00000000
1_000_00000000
1_000_00000000
1_000_000000fc
3_000_fc000000
5_000_00000000
1_000_00000077 // unknown byte in waiting
1_000_00000003
6_000_00000000
5_000_00000000
1_000_00000001
1_000_00000000
1_000_00000000
1_000_00000000
1_000_000000fc
3_000_fc000000
5_000_00000000
1_000_00000003 // step mode
5_002_00000000
2_000_0000009a
5_002_00000000
1_000_00000002
5_002_00000000
1_000_00000006 // step
4_000_0000009a
5_000_00000000

/* files.f */
verilog/debug_bus_pkg.sv
verilog/debug_cmd_pkg.sv
verilog/rx_word_assembler.sv
verilog/inst_mem_writer.sv
verilog/pc_report_sender.sv
verilog/debug_controller.sv
verilog/debug_unit.sv
tests/debug_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the debug unit testbench with verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module debug_unit_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vdebug_unit_tb > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation PASSED" "$log"; then
    exit 0
fi
exit 1

/* tests/debug_unit_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module debug_unit_tb
    import debug_bus_pkg::*;
    import debug_cmd_pkg::*;
();

    logic              clk;
    logic              reset;
    logic              halt;
    logic [byte_w-1:0] pc_byte;
    logic              rx_done_tick;
    logic [byte_w-1:0] rx_data_in;
    logic              tx_done_tick;
    mem_write_t        mem_wr;
    logic              ctrl_clk_mips;
    logic              debug;
    logic              tx_start;
    logic [byte_w-1:0] data_out;

    logic [47:0] stim [0:127];  // kind 4b, arg 12b, value 32b
    int          line_count;
    logic [31:0] rng;
    mem_write_t  writes [$];    // every cycle with mem_wr.we high

    debug_unit uut (
        .clk           (clk),
        .reset         (reset),
        .halt          (halt),
        .pc_byte       (pc_byte),
        .rx_done_tick  (rx_done_tick),
        .rx_data_in    (rx_data_in),
        .tx_done_tick  (tx_done_tick),
        .mem_wr        (mem_wr),
        .ctrl_clk_mips (ctrl_clk_mips),
        .debug         (debug),
        .tx_start      (tx_start),
        .data_out      (data_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // sampled mid cycle away from the driving edge
    always @(negedge clk)
    begin
        if (!reset && mem_wr.we)
            writes.push_back(mem_wr);
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
            stop_run($sformatf("CHECK FAILED at %0t: %s expected %h, got %h",
                               $time, name, expected, actual));
    endtask

    task automatic idle_random(input int lo, input int span);
        int n;
        rng = xorshift32(rng);
        n = lo + int'(rng % 32'(span));  // lo .. lo+span-1 cycles
        repeat (n) @(posedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        rx_data_in   <= b;
        rx_done_tick <= 1'b1;
        @(posedge clk);
        rx_done_tick <= 1'b0;
        idle_random(2, 8);
    endtask

    task automatic pulse_halt(input logic [7:0] pc);
        @(posedge clk);
        halt    <= 1'b1;
        pc_byte <= pc;  // stays after the pulse
        @(posedge clk);
        halt    <= 1'b0;
        @(posedge clk);  // controller has seen the halt
    endtask

    task automatic expect_write(input logic [11:0] addr, input logic [31:0] data);
        int         waited;
        mem_write_t got;
        waited = 0;
        while (writes.size() == 0 && waited < 12)
        begin
            @(posedge clk);
            waited++;
        end
        assert (writes.size() != 0)
        else
            stop_run($sformatf("no memory write arrived for address %0h", addr));
        got = writes.pop_front();
        check_value("mem_wr.addr", 32'(addr), 32'(got.addr));
        check_value("mem_wr.data", data, got.data);
    endtask

    task automatic expect_no_write();
        repeat (6) @(posedge clk);
        assert (writes.size() == 0)
        else
            stop_run($sformatf("unexpected memory write to address %0h", writes[0].addr));
    endtask

    // lv is {tx_start, ctrl_clk_mips, debug}
    task automatic expect_levels(input logic [2:0] lv);
        int waited;
        waited = 0;
        while ({tx_start, ctrl_clk_mips, debug} !== lv && waited < 8)
        begin
            @(posedge clk);
            waited++;
        end
        check_value("debug", 32'(lv[0]), 32'(debug));
        check_value("ctrl_clk_mips", 32'(lv[1]), 32'(ctrl_clk_mips));
        check_value("tx_start", 32'(lv[2]), 32'(tx_start));
    endtask

    task automatic expect_report(input logic [7:0] b);
        int waited;
        waited = 0;
        while (tx_start !== 1'b1 && waited < 16)
        begin
            @(posedge clk);
            waited++;
        end
        assert (tx_start === 1'b1)
        else
            stop_run("tx_start never rose for the pc report");
        check_value("data_out", 32'(b), 32'(data_out));
        idle_random(3, 10);  // transmitter busy
        check_value("tx_start", 32'(1), 32'(tx_start));
        check_value("data_out", 32'(b), 32'(data_out));
        tx_done_tick <= 1'b1;
        waited = 0;
        while (tx_start === 1'b1 && waited < 8)
        begin
            @(posedge clk);
            waited++;
        end
        tx_done_tick <= 1'b0;
        check_value("tx_start", 32'(0), 32'(tx_start));
    endtask

    ////////////////////////////////////////
    // stimulus replay
    ////////////////////////////////////////
    initial
    begin : main_seq
        int          idx;
        logic [3:0]  kind;
        logic [11:0] arg;
        logic [31:0] val;
        reset        = 1'b1;
        halt         = 1'b0;
        pc_byte      = '0;
        rx_done_tick = 1'b0;
        rx_data_in   = '0;
        tx_done_tick = 1'b0;
        rng          = 32'd57735;
        for (idx = 0; idx < 128; idx++)
            stim[idx] = {4'hf, 12'(idx), 32'(idx)};  // kind f marks unused entries
        $readmemh("tests/debug_stim.txt", stim);
        line_count = 0;
        while (line_count < 128 && stim[line_count][47:44] != 4'hf)
            line_count++;
        assert (line_count > 0)
        else
            stop_run("stimulus file tests/debug_stim.txt holds no entries");

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("mem_wr.we", 32'(0), 32'(mem_wr.we));
        check_value("mem_wr.addr", 32'(0), 32'(mem_wr.addr));
        check_value("data_out", 32'(0), 32'(data_out));

        for (idx = 0; idx < line_count; idx++)
        begin
            {kind, arg, val} = stim[idx];
            case (kind)
                4'h1: send_byte(val[7:0]);
                4'h2: pulse_halt(val[7:0]);
                4'h3: expect_write(arg, val);
                4'h4: expect_report(val[7:0]);
                4'h5: expect_levels(arg[2:0]);
                4'h6: expect_no_write();
                default: stop_run($sformatf("unknown stimulus kind %0h in entry %0d", kind, idx));
            endcase
        end
        expect_no_write();  // nothing left over

        $display("Simulation PASSED");
        $finish;
    end

    // watchdog
    initial
    begin
        @(negedge reset);
        repeat (line_count * 40) @(posedge clk);
        stop_run($sformatf("the run timed out after %0d cycles", line_count * 40));
    end

endmodule

`default_nettype wire

/* verilog/debug_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module debug_unit
    import debug_bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              halt,
    input  logic [byte_w-1:0] pc_byte,
    input  logic              rx_done_tick,
    input  logic [byte_w-1:0] rx_data_in,
    input  logic              tx_done_tick,
    output mem_write_t        mem_wr,
    output logic              ctrl_clk_mips,
    output logic              debug,
    output logic              tx_start,
    output logic [byte_w-1:0] data_out
);

    uart_byte_t rx_byte;
    inst_word_t word;
    logic       collect;
    logic       program_done;
    logic       send_req;
    logic       send_done;

    ////////////////////////////////////////
    // rx bytes -> words
    ////////////////////////////////////////
    rx_word_assembler u_rx (
        .clk          (clk),
        .reset        (reset),
        .rx_done_tick (rx_done_tick),
        .rx_data_in   (rx_data_in),
        .collect      (collect),
        .rx_byte      (rx_byte),
        .word         (word)
    );

    debug_controller u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .rx_byte       (rx_byte),
        .halt          (halt),
        .program_done  (program_done),
        .send_done     (send_done),
        .collect       (collect),
        .send_req      (send_req),
        .ctrl_clk_mips (ctrl_clk_mips),
        .debug         (debug)
    );

    ////////////////////////////////////////
    // memory and report side
    ////////////////////////////////////////
    inst_mem_writer u_writer (
        .clk          (clk),
        .reset        (reset),
        .word         (word),
        .collect      (collect),
        .mem_wr       (mem_wr),
        .program_done (program_done)
    );

    pc_report_sender u_sender (
        .clk          (clk),
        .reset        (reset),
        .send_req     (send_req),
        .pc_byte      (pc_byte),
        .tx_done_tick (tx_done_tick),
        .tx_start     (tx_start),
        .data_out     (data_out),
        .send_done    (send_done)
    );

endmodule

`default_nettype wire

/* verilog/debug_controller.sv */
`default_nettype none
`timescale 1ns/100ps

module debug_controller
    import debug_bus_pkg::*;
    import debug_cmd_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  uart_byte_t rx_byte,
    input  logic       halt,
    input  logic       program_done,
    input  logic       send_done,
    output logic       collect,
    output logic       send_req,
    output logic       ctrl_clk_mips,
    output logic       debug
);

    debug_state_e state_q;
    debug_state_e state_next;
    host_cmd_e    cmd;

    assign cmd = host_cmd_e'(rx_byte.data);

    ////////////////////////////////////////
    // state register
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state_q  <= st_idle;
            send_req <= 1'b0;
        end
        else
        begin
            state_q  <= state_next;
            send_req <= (state_next == st_sending) && (state_q != st_sending);  // entry pulse
        end
    end

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////
    always_comb
    begin
        state_next = state_q;
        case (state_q)
            st_idle:
            begin
                if (rx_byte.strobe && cmd == cmd_start)
                    state_next = st_programming;
            end
            st_programming:
            begin
                if (program_done)  // end word already in memory
                    state_next = st_waiting;
            end
            st_waiting:
            begin
                if (rx_byte.strobe)
                begin
                    case (cmd)
                        cmd_continuous: state_next = st_continuous;
                        cmd_step_mode:  state_next = st_step_by_step;
                        cmd_reprogram:  state_next = st_idle;
                        default:        state_next = st_idle;  // unknown byte
                    endcase
                end
            end
            st_step_by_step:
            begin
                if (rx_byte.strobe && cmd == cmd_step)
                    state_next = st_sending;
            end
            st_continuous:
            begin
                if (halt)
                    state_next = st_sending;
            end
            st_sending:
            begin
                if (send_done)
                    state_next = st_idle;
            end
            default:
            begin
                state_next = st_idle;
            end
        endcase
    end

    // levels decoded from the state
    assign collect       = (state_q == st_programming);
    assign debug         = (state_q == st_programming);
    assign ctrl_clk_mips = (state_q == st_continuous) || (state_q == st_step_by_step);

endmodule

`default_nettype wire

/* verilog/pc_report_sender.sv */
`default_nettype none
`timescale 1ns/100ps

module pc_report_sender
    import debug_bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              send_req,
    input  logic [byte_w-1:0] pc_byte,
    input  logic              tx_done_tick,
    output logic              tx_start,
    output logic [byte_w-1:0] data_out,
    output logic              send_done
);

    logic tx_done_prev;
    logic done_edge;

    assign done_edge = tx_done_tick & ~tx_done_prev;

    ////////////////////////////////////////
    // one byte report to the uart tx
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tx_done_prev <= 1'b0;
            tx_start     <= 1'b0;
            data_out     <= '0;
            send_done    <= 1'b0;
        end
        else
        begin
            tx_done_prev <= tx_done_tick;
            send_done    <= 1'b0;
            if (send_req)
            begin
                tx_start <= 1'b1;
                data_out <= pc_byte;  // low byte of the pc
            end
            else if (tx_start && done_edge)
            begin
                // transmitter finished, release the line
                tx_start  <= 1'b0;
                send_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/inst_mem_writer.sv */
`default_nettype none
`timescale 1ns/100ps

module inst_mem_writer
    import debug_bus_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  inst_word_t word,
    input  logic       collect,
    output mem_write_t mem_wr,
    output logic       program_done
);

    logic [addr_w-1:0] addr_cnt;  // next free address
    logic              wr_en;
    logic [addr_w-1:0] wr_addr;
    logic [word_w-1:0] wr_data;
    logic              end_word;

    assign end_word = &wr_data[end_opcode_msb:end_opcode_lsb];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            addr_cnt     <= '0;
            wr_en        <= 1'b0;
            wr_addr      <= '0;
            program_done <= 1'b0;
        end
        else
        begin
            wr_en        <= word.valid;
            program_done <= wr_en && end_word;  // flagged after the write
            if (!collect)
                addr_cnt <= '0;
            else if (word.valid)
            begin
                wr_addr  <= addr_cnt;
                addr_cnt <= addr_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (word.valid)
            wr_data <= word.data;
    end

    assign mem_wr = '{we: wr_en, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

/* verilog/rx_word_assembler.sv */
`default_nettype none
`timescale 1ns/100ps

module rx_word_assembler
    import debug_bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              rx_done_tick,
    input  logic [byte_w-1:0] rx_data_in,
    input  logic              collect,
    output uart_byte_t        rx_byte,
    output inst_word_t        word
);

    logic              rx_done_prev;
    logic              new_byte;
    logic              strobe_q;
    logic [byte_w-1:0] data_q;
    logic [1:0]        lane;        // byte lane of the next byte
    logic              word_valid;
    logic [word_w-1:0] word_data;

    assign new_byte = rx_done_tick & ~rx_done_prev;  // rx tick went high

    ////////////////////////////////////////
    // byte capture
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rx_done_prev <= 1'b0;
            strobe_q     <= 1'b0;
        end
        else
        begin
            rx_done_prev <= rx_done_tick;
            strobe_q     <= new_byte;
        end
    end

    always_ff @(posedge clk)
    begin
        if (new_byte)
            data_q <= rx_data_in;
    end

    ////////////////////////////////////////
    // word assembly, lsb first
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset || !collect)  // restart at lane 0 outside programming
        begin
            lane       <= 2'd0;
            word_valid <= 1'b0;
        end
        else
        begin
            word_valid <= strobe_q && (lane == 2'(bytes_per_word - 1));
            if (strobe_q)
                lane <= lane + 2'd1;  // wraps after the last lane
        end
    end

    always_ff @(posedge clk)
    begin
        if (strobe_q && collect)
            word_data[lane*byte_w +: byte_w] <= data_q;
    end

    assign rx_byte = '{strobe: strobe_q, data: data_q};
    assign word    = '{valid: word_valid, data: word_data};

endmodule

`default_nettype wire

/* verilog/debug_cmd_pkg.sv */
`default_nettype none

package debug_cmd_pkg;

    // bytes the host sends over the uart
    typedef enum logic [7:0] {
        cmd_start      = 8'h01,
        cmd_continuous = 8'h02,
        cmd_step_mode  = 8'h03,
        cmd_reprogram  = 8'h05,
        cmd_step       = 8'h06
    } host_cmd_e;

    // controller states
    typedef enum logic [2:0] {
        st_idle         = 3'd0,
        st_programming  = 3'd1,
        st_waiting      = 3'd2,
        st_step_by_step = 3'd3,
        st_continuous   = 3'd4,
        st_sending      = 3'd5
    } debug_state_e;

endpackage

`default_nettype wire

/* verilog/debug_bus_pkg.sv */
`default_nettype none

package debug_bus_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    localparam int byte_w         = 8;     // uart byte
    localparam int word_w         = 32;    // mips instruction
    localparam int addr_w         = 11;    // instruction memory depth 2k
    localparam int bytes_per_word = 4;

    // opcode field, all ones marks the last word of a program
    localparam int end_opcode_msb = 31;
    localparam int end_opcode_lsb = 26;

    ////////////////////////////////////////
    // bundles
    ////////////////////////////////////////
    typedef struct packed {
        logic              strobe;  // one cycle per received byte
        logic [byte_w-1:0] data;
    } uart_byte_t;

    typedef struct packed {
        logic              valid;
        logic [word_w-1:0] data;
    } inst_word_t;

    typedef struct packed {
        logic              we;
        logic [addr_w-1:0] addr;
        logic [word_w-1:0] data;
    } mem_write_t;

endpackage

`default_nettype wire
